// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "no result in $(LOG)"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/core_csr_unit.sv
`timescale 1ns/100ps
`default_nettype none

module core_csr_unit #(
    parameter int CORE_ID = 0
) (
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 csr_req_valid,
    input  core_pkg::csr_req_t  csr_req,
    output logic                csr_req_ready,

    output logic                csr_rsp_valid,
    output core_pkg::word_t     csr_rsp_data,
    input  wire                 csr_rsp_ready,

    input  wire                 busy,
    input  wire                 retire,
    output logic                start,
    output core_pkg::addr_t     start_pc,
    input  core_pkg::addr_t     pc,
    output core_pkg::reg_idx_t  reg_rd_idx,
    input  core_pkg::word_t     reg_rd_data
);
    import core_pkg::*;

    word_t retired;
    word_t rd_val;
    logic  req_fire;

    assign csr_req_ready = !busy && !csr_rsp_valid;
    assign req_fire      = csr_req_valid && csr_req_ready;

    assign reg_rd_idx = csr_req.addr[2:0];
    assign start      = req_fire && csr_req.rw && (csr_req.addr == CSR_START_PC);
    assign start_pc   = csr_req.data[29:0];

    // Old value at the address, returned for reads and writes alike
    always_comb begin
        case (csr_req.addr)
            CSR_START_PC: rd_val = {2'b00, pc};
            CSR_RETIRED:  rd_val = retired;
            CSR_CORE_ID:  rd_val = word_t'(CORE_ID);
            default: begin
                if (csr_req.addr[11:3] == CSR_REG_BASE[11:3])
                    rd_val = reg_rd_data;
                else
                    rd_val = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_rsp_valid <= 1'b0;
            retired       <= '0;
        end else begin
            if (req_fire)
                csr_rsp_valid <= 1'b1;
            else if (csr_rsp_ready)
                csr_rsp_valid <= 1'b0;
            if (start)
                retired <= '0;
            else if (retire)
                retired <= retired + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire)
            csr_rsp_data <= rd_val;
    end

endmodule

`default_nettype wire

// File: hdl/core_mem_unit.sv
`timescale 1ns/100ps
`default_nettype none

module core_mem_unit #(
    parameter int REQ_QUEUE_DEPTH = 4
) (
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 fetch_req_valid,
    input  core_pkg::mem_req_t  fetch_req,
    output logic                fetch_req_ready,

    input  wire                 data_req_valid,
    input  core_pkg::mem_req_t  data_req,
    output logic                data_req_ready,

    output logic                fetch_rsp_valid,
    output core_pkg::mem_rsp_t  fetch_rsp,
    input  wire                 fetch_rsp_ready,

    output logic                data_rsp_valid,
    output core_pkg::mem_rsp_t  data_rsp,
    input  wire                 data_rsp_ready,

    output logic                dram_req_valid,
    output core_pkg::mem_req_t  dram_req,
    input  wire                 dram_req_ready,

    input  wire                 dram_rsp_valid,
    input  core_pkg::mem_rsp_t  dram_rsp,
    output logic                dram_rsp_ready
);
    import core_pkg::*;

    localparam int PTR_W = $clog2(REQ_QUEUE_DEPTH);

    mem_req_t         queue [REQ_QUEUE_DEPTH];
    mem_req_t         push_req;
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W:0]   count;
    logic             full, push, pop;

    assign full = (count == (PTR_W + 1)'(REQ_QUEUE_DEPTH));

    // Data side has fixed priority
    assign data_req_ready  = !full;
    assign fetch_req_ready = !full && !data_req_valid;
    assign push            = (data_req_valid || fetch_req_valid) && !full;

    always_comb begin
        push_req     = data_req_valid ? data_req : fetch_req;
        push_req.tag = data_req_valid ? SRC_DATA : SRC_FETCH;
    end

    assign dram_req_valid = (count != '0);
    assign dram_req       = queue[rd_ptr];
    assign pop            = dram_req_valid && dram_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            queue[wr_ptr] <= push_req;
    end

    // Response steering by tag
    assign fetch_rsp       = dram_rsp;
    assign data_rsp        = dram_rsp;
    assign fetch_rsp_valid = dram_rsp_valid && (dram_rsp.tag == SRC_FETCH);
    assign data_rsp_valid  = dram_rsp_valid && (dram_rsp.tag == SRC_DATA);
    assign dram_rsp_ready  = (dram_rsp.tag == SRC_DATA) ? data_rsp_ready : fetch_rsp_ready;

endmodule

`default_nettype wire

// File: hdl/core_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module core_pipeline #(
    parameter int CORE_ID = 0
) (
    input  wire                 clk,
    input  wire                 rst,

    output logic                fetch_req_valid,
    output core_pkg::mem_req_t  fetch_req,
    input  wire                 fetch_req_ready,

    output logic                data_req_valid,
    output core_pkg::mem_req_t  data_req,
    input  wire                 data_req_ready,

    input  wire                 fetch_rsp_valid,
    input  core_pkg::mem_rsp_t  fetch_rsp,
    output logic                fetch_rsp_ready,

    input  wire                 data_rsp_valid,
    input  core_pkg::mem_rsp_t  data_rsp,
    output logic                data_rsp_ready,

    input  wire                 csr_req_valid,
    input  core_pkg::csr_req_t  csr_req,
    output logic                csr_req_ready,

    output logic                csr_rsp_valid,
    output core_pkg::word_t     csr_rsp_data,
    input  wire                 csr_rsp_ready,

    output logic                busy,
    output logic                ebreak
);
    import core_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_REQ,
        FETCH_WAIT,
        EXEC,
        MEM_REQ,
        MEM_WAIT,
        HALT
    } state_e;

    state_e   state, state_next;
    addr_t    pc;
    addr_t    start_pc;
    instr_t   instr;
    word_t    regs [8];
    word_t    rs_val, rd_val, eff;
    word_t    rd_wdata;
    reg_idx_t reg_rd_idx;
    logic     start, retire, rd_we;
    logic     is_load, is_store;

    assign is_load  = (instr.op == OP_LOAD);
    assign is_store = (instr.op == OP_STORE);

    // r0 is never written, so it reads zero
    assign rs_val = regs[instr.rs];
    assign rd_val = regs[instr.rd];
    assign eff    = rs_val + {{16{instr.imm[15]}}, instr.imm};

    assign fetch_req_valid = (state == FETCH_REQ);
    assign fetch_req       = '{rw: 1'b0, addr: pc, data: '0, tag: SRC_FETCH};
    assign fetch_rsp_ready = (state == FETCH_WAIT);

    assign data_req_valid = (state == MEM_REQ);
    assign data_req       = '{rw: is_store, addr: eff[29:0], data: rd_val, tag: SRC_DATA};
    assign data_rsp_ready = (state == MEM_WAIT) && is_load;

    assign busy   = (state != IDLE) && (state != HALT);
    assign ebreak = (state == HALT);

    always_comb begin
        state_next = state;
        retire     = 1'b0;
        case (state)
            IDLE, HALT: begin
                if (start)
                    state_next = FETCH_REQ;
            end
            FETCH_REQ: begin
                if (fetch_req_ready)
                    state_next = FETCH_WAIT;
            end
            FETCH_WAIT: begin
                if (fetch_rsp_valid)
                    state_next = EXEC;
            end
            EXEC: begin
                if (is_load || is_store) begin
                    state_next = MEM_REQ;
                end else begin
                    retire     = 1'b1;
                    state_next = (instr.op == OP_EBREAK) ? HALT : FETCH_REQ;
                end
            end
            MEM_REQ: begin
                if (data_req_ready)
                    state_next = MEM_WAIT;
            end
            MEM_WAIT: begin
                // Stores get no response
                if (is_store || data_rsp_valid) begin
                    retire     = 1'b1;
                    state_next = FETCH_REQ;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            state <= state_next;
            if (start)
                pc <= start_pc;
            else if (retire)
                pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && fetch_rsp_valid)
            instr <= instr_t'(fetch_rsp.data);
    end

    assign rd_wdata = (state == MEM_WAIT) ? data_rsp.data : eff;
    assign rd_we    = (instr.rd != '0) &&
                      ((state == EXEC && instr.op == OP_ADDI) ||
                       (state == MEM_WAIT && is_load && data_rsp_valid));

    always_ff @(posedge clk) begin
        if (rst)
            regs <= '{default: '0};
        else if (rd_we)
            regs[instr.rd] <= rd_wdata;
    end

    core_csr_unit #(
        .CORE_ID(CORE_ID)
    ) u_csr_unit (
        .clk           (clk),
        .rst           (rst),
        .csr_req_valid (csr_req_valid),
        .csr_req       (csr_req),
        .csr_req_ready (csr_req_ready),
        .csr_rsp_valid (csr_rsp_valid),
        .csr_rsp_data  (csr_rsp_data),
        .csr_rsp_ready (csr_rsp_ready),
        .busy          (busy),
        .retire        (retire),
        .start         (start),
        .start_pc      (start_pc),
        .pc            (pc),
        .reg_rd_idx    (reg_rd_idx),
        .reg_rd_data   (regs[reg_rd_idx])
    );

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [29:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  reg_idx_t;

    // DRAM tag doubles as the request source
    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_DATA  = 1'b1
    } mem_src_e;

    // Unlisted opcodes execute as no-ops
    typedef enum logic [3:0] {
        OP_ADDI   = 4'h1,
        OP_LOAD   = 4'h2,
        OP_STORE  = 4'h3,
        OP_EBREAK = 4'hf
    } op_e;

    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs;
        logic [5:0]  unused;
        logic [15:0] imm;
    } instr_t;

    typedef struct packed {
        logic     rw;
        addr_t    addr;
        word_t    data;
        mem_src_e tag;
    } mem_req_t;

    typedef struct packed {
        word_t    data;
        mem_src_e tag;
    } mem_rsp_t;

    typedef struct packed {
        logic      rw;
        csr_addr_t addr;
        word_t     data;
    } csr_req_t;

    // Registers r0..r7 sit at CSR_REG_BASE + idx
    localparam csr_addr_t CSR_START_PC = 12'h000;
    localparam csr_addr_t CSR_RETIRED  = 12'h001;
    localparam csr_addr_t CSR_CORE_ID  = 12'h002;
    localparam csr_addr_t CSR_REG_BASE = 12'h010;

endpackage

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top #(
    parameter int CORE_ID         = 0,
    parameter int REQ_QUEUE_DEPTH = 4
) (
    input  wire                 clk,
    input  wire                 rst,

    // DRAM request
    output logic                dram_req_valid,
    output core_pkg::mem_req_t  dram_req,
    input  wire                 dram_req_ready,

    // DRAM response
    input  wire                 dram_rsp_valid,
    input  core_pkg::mem_rsp_t  dram_rsp,
    output logic                dram_rsp_ready,

    // CSR request
    input  wire                 csr_req_valid,
    input  core_pkg::csr_req_t  csr_req,
    output logic                csr_req_ready,

    // CSR response
    output logic                csr_rsp_valid,
    output core_pkg::word_t     csr_rsp_data,
    input  wire                 csr_rsp_ready,

    output logic                busy,
    output logic                ebreak
);
    import core_pkg::*;

    mem_req_t fetch_req;
    mem_req_t data_req;
    mem_rsp_t fetch_rsp;
    mem_rsp_t data_rsp;
    logic     fetch_req_valid, fetch_req_ready;
    logic     data_req_valid, data_req_ready;
    logic     fetch_rsp_valid, fetch_rsp_ready;
    logic     data_rsp_valid, data_rsp_ready;

    core_pipeline #(
        .CORE_ID(CORE_ID)
    ) u_pipeline (
        .clk             (clk),
        .rst             (rst),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_req_ready  (data_req_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp),
        .data_rsp_ready  (data_rsp_ready),
        .csr_req_valid   (csr_req_valid),
        .csr_req         (csr_req),
        .csr_req_ready   (csr_req_ready),
        .csr_rsp_valid   (csr_rsp_valid),
        .csr_rsp_data    (csr_rsp_data),
        .csr_rsp_ready   (csr_rsp_ready),
        .busy            (busy),
        .ebreak          (ebreak)
    );

    core_mem_unit #(
        .REQ_QUEUE_DEPTH(REQ_QUEUE_DEPTH)
    ) u_mem_unit (
        .clk             (clk),
        .rst             (rst),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_req_ready  (data_req_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .fetch_rsp_ready (fetch_rsp_ready),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp),
        .data_rsp_ready  (data_rsp_ready),
        .dram_req_valid  (dram_req_valid),
        .dram_req        (dram_req),
        .dram_req_ready  (dram_req_ready),
        .dram_rsp_valid  (dram_rsp_valid),
        .dram_rsp        (dram_rsp),
        .dram_rsp_ready  (dram_rsp_ready)
    );

endmodule

`default_nettype wire

// File: sim.f
hdl/core_pkg.sv
hdl/core_csr_unit.sv
hdl/core_pipeline.sv
hdl/core_mem_unit.sv
hdl/core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_core.sv

// File: testbench/core_stim.txt
# M addr data: DRAM word, S pc: start, R idx value: register, W addr data: DRAM result
# C count: retired count in decimal, all other columns hex
M 00000010 12000005
M 00000011 1440fffe
M 00000012 26000040
M 00000013 18c00001
M 00000014 3840003c
M 00000015 2a40003c
M 00000016 0e000123
M 00000017 f0000000
M 00000040 12345678
S 00000010
R 1 00000005
R 2 00000003
R 3 12345678
R 4 12345679
R 5 12345679
R 7 00000000
W 00000040 12345678
W 00000041 12345679
C 8
M 00000080 1c00ffff
M 00000081 11800007
M 00000082 3c000050
M 00000083 22000050
M 00000084 f0000000
S 00000080
R 0 00000000
R 1 ffffffff
R 2 00000003
R 6 ffffffff
W 00000050 ffffffff
C 5

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int CORE_ID         = 5;
    localparam int REQ_QUEUE_DEPTH = 4;

    logic     clk;
    logic     rst;
    logic     dram_req_valid;
    mem_req_t dram_req;
    logic     dram_req_ready = 1'b0;
    logic     dram_rsp_valid = 1'b0;
    mem_rsp_t dram_rsp = '0;
    logic     dram_rsp_ready;
    logic     csr_req_valid;
    csr_req_t csr_req;
    logic     csr_req_ready;
    logic     csr_rsp_valid;
    word_t    csr_rsp_data;
    logic     csr_rsp_ready;
    logic     busy;
    logic     ebreak;

    // DRAM model state
    word_t    dram_mem [addr_t];
    word_t    rsp_data_q [$];
    mem_src_e rsp_tag_q [$];
    int       rsp_due_q [$];
    word_t    rsp_word;
    mem_src_e rsp_tag;
    mem_req_t held_req;
    logic     req_held = 1'b0;
    logic     rsp_stalled;

    int       cycle = 0;
    int       cycle_limit = 1000;
    string    wait_for = "reset";
    int       errors = 0;
    int       errors_at_open = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    string    test_name;
    logic     stim_ok;

    // Stim records in file order
    byte      rec_kind [$];
    word_t    rec_a [$];
    word_t    rec_b [$];

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    core_top #(
        .CORE_ID         (CORE_ID),
        .REQ_QUEUE_DEPTH (REQ_QUEUE_DEPTH)
    ) u_dut (
        .clk            (clk),
        .rst            (rst),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready),
        .csr_req_valid  (csr_req_valid),
        .csr_req        (csr_req),
        .csr_req_ready  (csr_req_ready),
        .csr_rsp_valid  (csr_rsp_valid),
        .csr_rsp_data   (csr_rsp_data),
        .csr_rsp_ready  (csr_rsp_ready),
        .busy           (busy),
        .ebreak         (ebreak)
    );

    // Unwritten words read back a value built from the address
    function automatic word_t dram_read(addr_t addr);
        if (dram_mem.exists(addr))
            return dram_mem[addr];
        return {2'b11, addr};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t held);
        if (got !== held) begin
            $display("mismatch dram_req: got %h held %h", got, held);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name      = name;
        errors_at_open = errors;
    endtask

    task automatic close_test();
        tests_run++;
        if (errors == errors_at_open) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_at_open);
        end
    endtask

    // Called right after a rising edge, returns on the edge that takes the response
    task automatic csr_access(input logic rw, input csr_addr_t addr, input word_t data,
                              output word_t rdata);
        wait_for      = "csr response";
        csr_req_valid <= 1'b1;
        csr_req       <= '{rw: rw, addr: addr, data: data};
        @(posedge clk);
        while (!csr_req_ready)
            @(posedge clk);
        csr_req_valid <= 1'b0;
        @(posedge clk);
        while (!csr_rsp_valid)
            @(posedge clk);
        rdata = csr_rsp_data;
    endtask

    task automatic read_stim(output logic ok);
        int    fd;
        int    code;
        int    m_count;
        byte   kind;
        word_t a;
        word_t b;
        string line;
        m_count = 0;
        fd = $fopen("testbench/core_stim.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1)
                    break;
                a = '0;
                b = '0;
                if (kind == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    if (kind == "C")
                        code = $fscanf(fd, "%d", a);
                    else if (kind == "S")
                        code = $fscanf(fd, "%h", a);
                    else
                        code = $fscanf(fd, "%h %h", a, b);
                    if (kind == "M")
                        m_count++;
                    rec_kind.push_back(kind);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                end
            end
            $fclose(fd);
            cycle_limit = 200 + 40 * m_count;
        end
    endtask

    task automatic run_program(input word_t start_pc, input word_t exp_old);
        word_t rdata;
        csr_access(1'b1, CSR_START_PC, start_pc, rdata);
        check_word("csr start_pc old", rdata, exp_old);
        check_bit("busy", busy, 1'b1);
        wait_for = "ebreak";
        while (busy || !ebreak) begin
            if (busy)
                check_bit("csr_req_ready", csr_req_ready, 1'b0);
            @(posedge clk);
        end
    endtask

    task automatic run_tests();
        word_t rdata;
        word_t exp_old;
        int    prog;
        prog    = 0;
        exp_old = '0;
        @(posedge clk);
        while (rst)
            @(posedge clk);
        csr_rsp_ready <= 1'b1;

        open_test("reset");
        check_bit("busy", busy, 1'b0);
        check_bit("ebreak", ebreak, 1'b0);
        check_bit("dram_req_valid", dram_req_valid, 1'b0);
        check_bit("csr_rsp_valid", csr_rsp_valid, 1'b0);
        check_bit("csr_req_ready", csr_req_ready, 1'b1);
        close_test();

        open_test("csr");
        csr_access(1'b0, CSR_CORE_ID, '0, rdata);
        check_word("csr core_id", rdata, word_t'(CORE_ID));
        for (int i = 1; i < 8; i++) begin
            csr_access(1'b0, CSR_REG_BASE + csr_addr_t'(i), '0, rdata);
            check_word($sformatf("r%0d", i), rdata, '0);
        end
        close_test();

        for (int i = 0; i < rec_kind.size(); i++) begin
            case (rec_kind[i])
                "M": dram_mem[rec_a[i][29:0]] = rec_b[i];
                "S": begin
                    if (prog > 0)
                        close_test();
                    open_test($sformatf("program %0d", prog));
                    run_program(rec_a[i], exp_old);
                    exp_old = rec_a[i];
                    prog++;
                end
                "R": begin
                    csr_access(1'b0, CSR_REG_BASE + csr_addr_t'(rec_a[i]), '0, rdata);
                    check_word($sformatf("r%0d", rec_a[i]), rdata, rec_b[i]);
                end
                "W": begin
                    check_word($sformatf("dram[%h]", rec_a[i][29:0]),
                               dram_read(rec_a[i][29:0]), rec_b[i]);
                end
                "C": begin
                    csr_access(1'b0, CSR_RETIRED, '0, rdata);
                    check_word("csr retired", rdata, rec_a[i]);
                    // No branches, so the PC ends at start plus retired count
                    exp_old = exp_old + rec_a[i];
                end
                default: begin
                    $display("unknown stim record kind %c", rec_kind[i]);
                    errors++;
                end
            endcase
        end
        if (prog > 0)
            close_test();
    endtask

    // DRAM model with random ready and in-order responses
    always @(posedge clk) begin
        if (rst) begin
            dram_req_ready <= 1'b0;
            dram_rsp_valid <= 1'b0;
            req_held = 1'b0;
            rsp_data_q.delete();
            rsp_tag_q.delete();
            rsp_due_q.delete();
        end else begin
            if (req_held) begin
                check_bit("dram_req_valid", dram_req_valid, 1'b1);
                check_req(dram_req, held_req);
            end
            req_held = dram_req_valid && !dram_req_ready;
            held_req = dram_req;
            if (dram_req_valid && dram_req_ready) begin
                if (dram_req.rw) begin
                    dram_mem[dram_req.addr] = dram_req.data;
                end else begin
                    rsp_data_q.push_back(dram_read(dram_req.addr));
                    rsp_tag_q.push_back(dram_req.tag);
                    rsp_due_q.push_back(cycle + int'($urandom % 8));
                end
            end
            // One request in flight, so the core always waits for the response
            if (dram_rsp_valid)
                check_bit("dram_rsp_ready", dram_rsp_ready, 1'b1);
            rsp_stalled = dram_rsp_valid && !dram_rsp_ready;
            if (!rsp_stalled) begin
                if (rsp_data_q.size() != 0 && rsp_due_q[0] <= cycle) begin
                    rsp_word = rsp_data_q.pop_front();
                    rsp_tag  = rsp_tag_q.pop_front();
                    void'(rsp_due_q.pop_front());
                    dram_rsp       <= '{data: rsp_word, tag: rsp_tag};
                    dram_rsp_valid <= 1'b1;
                end else begin
                    dram_rsp_valid <= 1'b0;
                end
            end
            dram_req_ready <= ($urandom % 4) != 0;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout waiting for %s", wait_for);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        csr_req_valid = 1'b0;
        csr_req       = '0;
        csr_rsp_ready = 1'b0;
        void'($urandom(54));
        read_stim(stim_ok);
        if (!stim_ok) begin
            $display("cannot open testbench/core_stim.txt");
            $display("Simulation FAILED");
            $finish;
        end else begin
            run_tests();
            $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
            if (errors == 0)
                $display("Simulation PASSED");
            else
                $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire
